/* Bender.yml */
package:
  name: rsa

sources:
  - rtl/rsa_pkg.sv
  - rtl/skew_line.sv
  - rtl/pe_mac.sv
  - rtl/sync_adder.sv
  - rtl/pe_array.sv
  - rtl/rsa_ctrl.sv
  - rtl/rsa_top.sv
  - target: test
    files:
      - tb/rsa_assertions.sv
      - tb/rsa_tb.sv

/* all.f */
rtl/rsa_pkg.sv
rtl/skew_line.sv
rtl/pe_mac.sv
rtl/sync_adder.sv
rtl/pe_array.sv
rtl/rsa_ctrl.sv
rtl/rsa_top.sv
tb/rsa_assertions.sv
tb/rsa_tb.sv

/* rtl/pe_array.sv */
`timescale 1ns/1ps
`default_nettype none

module pe_array (
  input  logic                                          clk,
  input  logic                                          i_rst_n,
  input  logic [1:0]                                    i_mode,
  input  rsa_pkg::rsa_word_t [rsa_pkg::ARR_X-1:0]       i_a_data,
  input  rsa_pkg::rsa_word_t [rsa_pkg::ARR_Y-1:0]       i_b_data,
  input  logic [rsa_pkg::ARR_Y-1:0]                     i_cal_en,
  input  logic [rsa_pkg::ARR_Y-1:0]                     i_cal_done,
  input  logic                                          i_drain_load,
  input  logic                                          i_drain_shift,
  input  rsa_pkg::rsa_word_t [rsa_pkg::ARR_X-1:0]       i_m_data,
  input  rsa_pkg::adder_mode_t [rsa_pkg::ARR_X-1:0]     i_adder_mode,
  output rsa_pkg::rsa_word_t [rsa_pkg::ARR_X-1:0]       o_c_data,
  output logic [rsa_pkg::ARR_X-1:0]                     o_c_valid
);

  localparam int X = rsa_pkg::ARR_X;
  localparam int Y = rsa_pkg::ARR_Y;

  logic row_w2e;
  logic col_n2s;

  // eastward and westward links, index c sits west of PE column c
  rsa_pkg::rsa_word_t a_east   [X][Y+1];
  rsa_pkg::rsa_word_t a_west   [X][Y+1];
  rsa_pkg::rsa_word_t res_east [X][Y+1];
  rsa_pkg::rsa_word_t res_west [X][Y+1];
  logic               rv_east  [X][Y+1];
  logic               rv_west  [X][Y+1];

  // southward and northward links, index r sits north of PE row r
  rsa_pkg::rsa_word_t b_south  [X+1][Y];
  rsa_pkg::rsa_word_t b_north  [X+1][Y];
  logic               en_south [X+1][Y];
  logic               en_north [X+1][Y];
  logic               dn_south [X+1][Y];
  logic               dn_north [X+1][Y];

  assign row_w2e = (i_mode[0] == rsa_pkg::DIR_W2E);
  assign col_n2s = (i_mode[1] == rsa_pkg::DIR_N2S);

  for (genvar r = 0; r < X; r++) begin : g_row
    rsa_pkg::rsa_word_t row_res;
    logic               row_rval;

    // A enters only on the selected side
    assign a_east[r][0] = row_w2e ? i_a_data[r] : '0;
    assign a_west[r][Y] = row_w2e ? '0 : i_a_data[r];
    // drain boundary feeds empty slots
    assign res_east[r][0] = '0;
    assign res_west[r][Y] = '0;
    assign rv_east[r][0]  = 1'b0;
    assign rv_west[r][Y]  = 1'b0;

    assign row_res  = row_w2e ? res_west[r][0] : res_east[r][Y];
    assign row_rval = row_w2e ? rv_west[r][0] : rv_east[r][Y];

    sync_adder u_adder (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_mode  (i_adder_mode[r]),
      .i_valid (row_rval),
      .i_m     (i_m_data[r]),
      .i_c     (row_res),
      .o_valid (o_c_valid[r]),
      .o_sum   (o_c_data[r])
    );
  end

  for (genvar c = 0; c < Y; c++) begin : g_col
    assign b_south[0][c]  = col_n2s ? i_b_data[c] : '0;
    assign b_north[X][c]  = col_n2s ? '0 : i_b_data[c];
    assign en_south[0][c] = col_n2s ? i_cal_en[c] : 1'b0;
    assign en_north[X][c] = col_n2s ? 1'b0 : i_cal_en[c];
    assign dn_south[0][c] = col_n2s ? i_cal_done[c] : 1'b0;
    assign dn_north[X][c] = col_n2s ? 1'b0 : i_cal_done[c];
  end

  for (genvar r = 0; r < X; r++) begin : g_pe_x
    for (genvar c = 0; c < Y; c++) begin : g_pe_y
      pe_mac u_pe (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_mode        (i_mode),
        .i_a_w         (a_east[r][c]),
        .i_a_e         (a_west[r][c+1]),
        .o_a_w         (a_west[r][c]),
        .o_a_e         (a_east[r][c+1]),
        .i_b_n         (b_south[r][c]),
        .i_b_s         (b_north[r+1][c]),
        .o_b_n         (b_north[r][c]),
        .o_b_s         (b_south[r+1][c]),
        .i_en_n        (en_south[r][c]),
        .i_en_s        (en_north[r+1][c]),
        .o_en_n        (en_north[r][c]),
        .o_en_s        (en_south[r+1][c]),
        .i_done_n      (dn_south[r][c]),
        .i_done_s      (dn_north[r+1][c]),
        .o_done_n      (dn_north[r][c]),
        .o_done_s      (dn_south[r+1][c]),
        .i_drain_load  (i_drain_load),
        .i_drain_shift (i_drain_shift),
        .i_res_w       (res_east[r][c]),
        .i_res_e       (res_west[r][c+1]),
        .o_res_w       (res_west[r][c]),
        .o_res_e       (res_east[r][c+1]),
        .i_rval_w      (rv_east[r][c]),
        .i_rval_e      (rv_west[r][c+1]),
        .o_rval_w      (rv_west[r][c]),
        .o_rval_e      (rv_east[r][c+1])
      );
    end
  end

endmodule

`default_nettype wire

/* rtl/pe_mac.sv */
`timescale 1ns/1ps
`default_nettype none

module pe_mac (
  input  logic               clk,
  input  logic               i_rst_n,
  input  logic [1:0]         i_mode,
  input  rsa_pkg::rsa_word_t i_a_w,
  input  rsa_pkg::rsa_word_t i_a_e,
  output rsa_pkg::rsa_word_t o_a_w,
  output rsa_pkg::rsa_word_t o_a_e,
  input  rsa_pkg::rsa_word_t i_b_n,
  input  rsa_pkg::rsa_word_t i_b_s,
  output rsa_pkg::rsa_word_t o_b_n,
  output rsa_pkg::rsa_word_t o_b_s,
  input  logic               i_en_n,
  input  logic               i_en_s,
  output logic               o_en_n,
  output logic               o_en_s,
  input  logic               i_done_n,
  input  logic               i_done_s,
  output logic               o_done_n,
  output logic               o_done_s,
  input  logic               i_drain_load,
  input  logic               i_drain_shift,
  input  rsa_pkg::rsa_word_t i_res_w,
  input  rsa_pkg::rsa_word_t i_res_e,
  output rsa_pkg::rsa_word_t o_res_w,
  output rsa_pkg::rsa_word_t o_res_e,
  input  logic               i_rval_w,
  input  logic               i_rval_e,
  output logic               o_rval_w,
  output logic               o_rval_e
);

  logic               row_w2e;
  logic               col_n2s;
  rsa_pkg::rsa_word_t a_in;
  rsa_pkg::rsa_word_t b_in;
  logic               en_in;
  logic               done_in;
  rsa_pkg::rsa_word_t up_res;
  logic               up_rval;
  rsa_pkg::rsa_word_t a_q;
  rsa_pkg::rsa_word_t b_q;
  logic               en_q;
  logic               done_q;
  rsa_pkg::rsa_word_t acc;
  rsa_pkg::rsa_word_t res;
  rsa_pkg::rsa_word_t chain_q;
  logic               rval_q;

  assign row_w2e = (i_mode[0] == rsa_pkg::DIR_W2E);
  assign col_n2s = (i_mode[1] == rsa_pkg::DIR_N2S);

  // upstream side for operands
  assign a_in    = row_w2e ? i_a_w : i_a_e;
  assign b_in    = col_n2s ? i_b_n : i_b_s;
  assign en_in   = col_n2s ? i_en_n : i_en_s;
  assign done_in = col_n2s ? i_done_n : i_done_s;

  // drain flows back toward the A entry edge
  assign up_res  = row_w2e ? i_res_e : i_res_w;
  assign up_rval = row_w2e ? i_rval_e : i_rval_w;

  always_ff @(posedge clk) begin
    a_q <= a_in;
    b_q <= b_in;
    if (done_in) begin
      res <= acc;
    end
    if (i_drain_load) begin
      chain_q <= res;
    end else if (i_drain_shift) begin
      chain_q <= up_res;
    end
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      en_q   <= 1'b0;
      done_q <= 1'b0;
      acc    <= '0;
      rval_q <= 1'b0;
    end else begin
      en_q   <= en_in;
      done_q <= done_in;
      // freeze and clear for the next job
      if (done_in) begin
        acc <= '0;
      end else if (en_in) begin
        acc <= acc + a_in * b_in;
      end
      if (i_drain_load) begin
        rval_q <= 1'b1;
      end else if (i_drain_shift) begin
        rval_q <= up_rval;
      end
    end
  end

  assign o_a_w    = a_q;
  assign o_a_e    = a_q;
  assign o_b_n    = b_q;
  assign o_b_s    = b_q;
  assign o_en_n   = en_q;
  assign o_en_s   = en_q;
  assign o_done_n = done_q;
  assign o_done_s = done_q;
  assign o_res_w  = chain_q;
  assign o_res_e  = chain_q;
  assign o_rval_w = rval_q;
  assign o_rval_e = rval_q;

endmodule

`default_nettype wire

/* rtl/rsa_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module rsa_ctrl (
  input  logic                      clk,
  input  logic                      i_rst_n,
  input  logic                      i_start,
  input  logic [1:0]                i_mode,
  input  logic [rsa_pkg::K_W-1:0]   i_k_len,
  input  logic                      i_in_valid,
  output logic [1:0]                o_mode_q,
  output logic [rsa_pkg::ARR_Y-1:0] o_cal_en,
  output logic [rsa_pkg::ARR_Y-1:0] o_cal_done,
  output logic                      o_drain_load,
  output logic                      o_drain_shift,
  output logic                      o_busy,
  output logic                      o_done
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FEED,
    ST_WAVE,
    ST_DRAIN,
    ST_FLUSH
  } state_t;

  state_t                  state;
  logic [rsa_pkg::K_W-1:0] cnt;
  logic [rsa_pkg::K_W-1:0] k_len_q;
  logic [1:0]              mode_q;
  logic                    done_q;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state   <= ST_IDLE;
      cnt     <= '0;
      k_len_q <= '0;
      mode_q  <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (i_start) begin
            mode_q  <= i_mode;
            k_len_q <= i_k_len;
            cnt     <= '0;
            state   <= ST_FEED;
          end
        end
        ST_FEED: begin
          // count accepted operand beats
          if (i_in_valid) begin
            if (cnt == k_len_q - 1'b1) begin
              cnt   <= '0;
              state <= ST_WAVE;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
        end
        ST_WAVE: begin
          // done strobe still crossing the grid
          if (cnt == rsa_pkg::WAVE_LAT - 1) begin
            cnt   <= '0;
            state <= ST_DRAIN;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        ST_DRAIN: begin
          // one load beat then ARR_Y shifts
          if (cnt == rsa_pkg::ARR_Y) begin
            cnt   <= '0;
            state <= ST_FLUSH;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        ST_FLUSH: begin
          // row adder holds the last word
          state  <= ST_IDLE;
          done_q <= 1'b1;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  assign o_mode_q      = mode_q;
  assign o_cal_en      = {rsa_pkg::ARR_Y{(state == ST_FEED) && i_in_valid}};
  assign o_cal_done    = {rsa_pkg::ARR_Y{(state == ST_WAVE) && (cnt == '0)}};
  assign o_drain_load  = (state == ST_DRAIN) && (cnt == '0);
  assign o_drain_shift = (state == ST_DRAIN) && (cnt != '0);
  assign o_busy        = (state != ST_IDLE);
  assign o_done        = done_q;

endmodule

`default_nettype wire

/* rtl/rsa_pkg.sv */
`default_nettype none

package rsa_pkg;

  // array geometry and word size
  localparam int RSA_DW = 16;
  localparam int ARR_X  = 4;
  localparam int ARR_Y  = 4;

  // longest inner dimension and its count width
  localparam int K_MAX = 16;
  localparam int K_W   = 5;

  typedef logic [RSA_DW-1:0] rsa_word_t;

  // mode bit 0, row flow of A
  localparam logic DIR_W2E = 1'b0;
  localparam logic DIR_E2W = 1'b1;

  // mode bit 1, column flow of B
  localparam logic DIR_N2S = 1'b0;
  localparam logic DIR_S2N = 1'b1;

  // row adder combination of product and M
  typedef enum logic [1:0] {
    ADD_PASS = 2'd0,
    ADD_M    = 2'd1,
    SUB_M    = 2'd2,
    M_SUB    = 2'd3
  } adder_mode_t;

  // last operand in until every PE has seen done
  localparam int WAVE_LAT = ARR_X + ARR_Y;

endpackage

`default_nettype wire

/* rtl/rsa_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rsa_top (
  input  logic                                      clk,
  input  logic                                      i_rst_n,
  input  logic                                      i_start,
  input  logic [1:0]                                i_mode,
  input  logic [rsa_pkg::K_W-1:0]                   i_k_len,
  input  logic                                      i_in_valid,
  input  rsa_pkg::rsa_word_t [rsa_pkg::ARR_X-1:0]   i_a_data,
  input  rsa_pkg::rsa_word_t [rsa_pkg::ARR_Y-1:0]   i_b_data,
  input  rsa_pkg::adder_mode_t [rsa_pkg::ARR_X-1:0] i_adder_mode,
  input  rsa_pkg::rsa_word_t [rsa_pkg::ARR_X-1:0]   i_m_data,
  output logic                                      o_busy,
  output logic [rsa_pkg::ARR_X-1:0]                 o_c_valid,
  output rsa_pkg::rsa_word_t [rsa_pkg::ARR_X-1:0]   o_c_data,
  output logic                                      o_done
);

  logic [1:0]                              mode_q;
  logic [rsa_pkg::ARR_Y-1:0]               cal_en;
  logic [rsa_pkg::ARR_Y-1:0]               cal_done;
  logic                                    drain_load;
  logic                                    drain_shift;
  rsa_pkg::rsa_word_t                      a_lane_in   [rsa_pkg::ARR_X];
  rsa_pkg::rsa_word_t                      a_lane_out  [rsa_pkg::ARR_X];
  rsa_pkg::rsa_word_t                      b_lane_in   [rsa_pkg::ARR_Y];
  rsa_pkg::rsa_word_t                      b_lane_out  [rsa_pkg::ARR_Y];
  logic [1:0]                              ctl_lane_in [rsa_pkg::ARR_Y];
  logic [1:0]                              ctl_lane_out[rsa_pkg::ARR_Y];
  rsa_pkg::rsa_word_t [rsa_pkg::ARR_X-1:0] a_skew;
  rsa_pkg::rsa_word_t [rsa_pkg::ARR_Y-1:0] b_skew;
  logic [rsa_pkg::ARR_Y-1:0]               en_skew;
  logic [rsa_pkg::ARR_Y-1:0]               done_skew;

  rsa_ctrl u_ctrl (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_start       (i_start),
    .i_mode        (i_mode),
    .i_k_len       (i_k_len),
    .i_in_valid    (i_in_valid),
    .o_mode_q      (mode_q),
    .o_cal_en      (cal_en),
    .o_cal_done    (cal_done),
    .o_drain_load  (drain_load),
    .o_drain_shift (drain_shift),
    .o_busy        (o_busy),
    .o_done        (o_done)
  );

  for (genvar r = 0; r < rsa_pkg::ARR_X; r++) begin : g_a_lane
    assign a_lane_in[r] = i_a_data[r];
    assign a_skew[r]    = a_lane_out[r];
  end

  // en and done share a lane so they stay aligned with B
  for (genvar c = 0; c < rsa_pkg::ARR_Y; c++) begin : g_b_lane
    assign b_lane_in[c]   = i_b_data[c];
    assign b_skew[c]      = b_lane_out[c];
    assign ctl_lane_in[c] = {cal_en[c], cal_done[c]};
    assign en_skew[c]     = ctl_lane_out[c][1];
    assign done_skew[c]   = ctl_lane_out[c][0];
  end

  // row delay follows the column direction
  skew_line #(
    .LANES  (rsa_pkg::ARR_X),
    .lane_t (rsa_pkg::rsa_word_t)
  ) u_skew_a (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_reverse (mode_q[1] == rsa_pkg::DIR_S2N),
    .i_lane    (a_lane_in),
    .o_lane    (a_lane_out)
  );

  // column delay follows the row direction
  skew_line #(
    .LANES  (rsa_pkg::ARR_Y),
    .lane_t (rsa_pkg::rsa_word_t)
  ) u_skew_b (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_reverse (mode_q[0] == rsa_pkg::DIR_E2W),
    .i_lane    (b_lane_in),
    .o_lane    (b_lane_out)
  );

  skew_line #(
    .LANES  (rsa_pkg::ARR_Y),
    .lane_t (logic [1:0])
  ) u_skew_ctl (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_reverse (mode_q[0] == rsa_pkg::DIR_E2W),
    .i_lane    (ctl_lane_in),
    .o_lane    (ctl_lane_out)
  );

  pe_array u_array (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_mode        (mode_q),
    .i_a_data      (a_skew),
    .i_b_data      (b_skew),
    .i_cal_en      (en_skew),
    .i_cal_done    (done_skew),
    .i_drain_load  (drain_load),
    .i_drain_shift (drain_shift),
    .i_m_data      (i_m_data),
    .i_adder_mode  (i_adder_mode),
    .o_c_data      (o_c_data),
    .o_c_valid     (o_c_valid)
  );

endmodule

`default_nettype wire

/* rtl/skew_line.sv */
`timescale 1ns/1ps
`default_nettype none

module skew_line #(
  parameter int  LANES  = 4,
  parameter type lane_t = logic
) (
  input  logic  clk,
  input  logic  i_rst_n,
  input  logic  i_reverse,
  input  lane_t i_lane [LANES],
  output lane_t o_lane [LANES]
);

  for (genvar l = 0; l < LANES; l++) begin : g_lane
    localparam int FWD   = l;
    localparam int REV   = LANES - 1 - l;
    localparam int DEPTH = (FWD > REV) ? FWD : REV;

    if (DEPTH == 0) begin : g_pass
      assign o_lane[l] = i_lane[l];
    end else begin : g_chain
      lane_t regs [1:DEPTH];
      lane_t fwd_tap;
      lane_t rev_tap;

      // only as deep as the longer of the two delays
      always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
          for (int t = 1; t <= DEPTH; t++) begin
            regs[t] <= '0;
          end
        end else begin
          regs[1] <= i_lane[l];
          for (int t = 2; t <= DEPTH; t++) begin
            regs[t] <= regs[t-1];
          end
        end
      end

      if (FWD == 0) begin : g_fwd_zero
        assign fwd_tap = i_lane[l];
      end else begin : g_fwd_reg
        assign fwd_tap = regs[FWD];
      end

      if (REV == 0) begin : g_rev_zero
        assign rev_tap = i_lane[l];
      end else begin : g_rev_reg
        assign rev_tap = regs[REV];
      end

      assign o_lane[l] = i_reverse ? rev_tap : fwd_tap;
    end
  end

endmodule

`default_nettype wire

/* rtl/sync_adder.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_adder (
  input  logic                 clk,
  input  logic                 i_rst_n,
  input  rsa_pkg::adder_mode_t i_mode,
  input  logic                 i_valid,
  input  rsa_pkg::rsa_word_t   i_m,
  input  rsa_pkg::rsa_word_t   i_c,
  output logic                 o_valid,
  output rsa_pkg::rsa_word_t   o_sum
);

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid;
    end
  end

  // wraps modulo 2^RSA_DW
  always_ff @(posedge clk) begin
    if (i_valid) begin
      case (i_mode)
        rsa_pkg::ADD_M: o_sum <= i_c + i_m;
        rsa_pkg::SUB_M: o_sum <= i_c - i_m;
        rsa_pkg::M_SUB: o_sum <= i_m - i_c;
        default:        o_sum <= i_c;
      endcase
    end
  end

endmodule

`default_nettype wire

/* tb/rsa_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module rsa_assertions (
  input logic                      clk,
  input logic                      i_rst_n,
  input logic                      i_start,
  input logic                      i_busy,
  input logic [rsa_pkg::ARR_X-1:0] i_c_valid,
  input logic                      i_done
);

  logic started;
  int   fail_cnt = 0;

  // set by the first start after reset
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      started <= 1'b0;
    end else if (i_start) begin
      started <= 1'b1;
    end
  end

  a_done_pulse : assert property (@(posedge clk) disable iff (!i_rst_n)
    i_done |=> !i_done)
    else begin
      fail_cnt++;
      $error("o_done stayed high for more than one cycle");
    end

  a_valid_busy : assert property (@(posedge clk) disable iff (!i_rst_n)
    !i_busy |-> (i_c_valid == '0))
    else begin
      fail_cnt++;
      $error("o_c_valid is high while o_busy is low");
    end

  // a start during a job is ignored unless that job ends right there
  a_start_busy : assert property (@(posedge clk) disable iff (!i_rst_n)
    (i_start && i_busy) |=> (i_busy || i_done))
    else begin
      fail_cnt++;
      $error("a start during a busy job changed o_busy");
    end

  a_quiet_reset : assert property (@(posedge clk) disable iff (!i_rst_n)
    !started |-> !(i_busy || i_done || (|i_c_valid)))
    else begin
      fail_cnt++;
      $error("a control output went high before the first start");
    end

endmodule

bind rsa_top rsa_assertions u_assertions (
  .clk       (clk),
  .i_rst_n   (i_rst_n),
  .i_start   (i_start),
  .i_busy    (o_busy),
  .i_c_valid (o_c_valid),
  .i_done    (o_done)
);

`default_nettype wire

/* tb/rsa_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rsa_tb;

  localparam int X         = rsa_pkg::ARR_X;
  localparam int Y         = rsa_pkg::ARR_Y;
  localparam int VEC_WORDS = 512;
  localparam int HDR_WORDS = 3 + 2 * X;

  logic                         clk;
  logic                         i_rst_n;
  logic                         i_start;
  logic [1:0]                   i_mode;
  logic [rsa_pkg::K_W-1:0]      i_k_len;
  logic                         i_in_valid;
  rsa_pkg::rsa_word_t [X-1:0]   i_a_data;
  rsa_pkg::rsa_word_t [Y-1:0]   i_b_data;
  rsa_pkg::adder_mode_t [X-1:0] i_adder_mode;
  rsa_pkg::rsa_word_t [X-1:0]   i_m_data;
  logic                         o_busy;
  logic [X-1:0]                 o_c_valid;
  rsa_pkg::rsa_word_t [X-1:0]   o_c_data;
  logic                         o_done;

  logic [15:0]        vec_mem [VEC_WORDS];
  rsa_pkg::rsa_word_t exp_c [X][Y];
  logic [1:0]         job_mode;
  int                 vec_ptr;
  int                 rx_cnt    [X];
  int                 first_cyc [X];
  int                 last_cyc  [X];
  int                 last_in_cyc;
  int                 done_cnt;
  int                 done_cyc;
  int                 cyc;
  int                 cycle_limit;
  int                 checks;
  int                 errors;

  rsa_top u_dut (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_start      (i_start),
    .i_mode       (i_mode),
    .i_k_len      (i_k_len),
    .i_in_valid   (i_in_valid),
    .i_a_data     (i_a_data),
    .i_b_data     (i_b_data),
    .i_adder_mode (i_adder_mode),
    .i_m_data     (i_m_data),
    .o_busy       (o_busy),
    .o_c_valid    (o_c_valid),
    .o_c_data     (o_c_data),
    .o_done       (o_done)
  );

  always #10 clk = ~clk;

  task automatic check_word(input logic [31:0] actual, input logic [31:0] expected,
                            input string what, input int row, input int col);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Mismatch at time %0t: %s, row %0d col %0d, got %h expected %h",
               $time, what, row, col, actual, expected);
    end
  endtask

  // one job from the vector memory, starting at vec_ptr
  task automatic run_job();
    int k;
    int probe;
    int beat;
    k        = vec_mem[vec_ptr + 1];
    probe    = vec_mem[vec_ptr + 2];
    beat     = vec_ptr + HDR_WORDS;
    job_mode = vec_mem[vec_ptr][1:0];
    done_cnt = 0;
    for (int r = 0; r < X; r++) begin
      rx_cnt[r] = 0;
      for (int c = 0; c < Y; c++) begin
        exp_c[r][c] = vec_mem[beat + (X + Y) * k + r * Y + c];
      end
    end
    @(posedge clk);
    i_start <= 1'b1;
    i_mode  <= job_mode;
    i_k_len <= k[rsa_pkg::K_W-1:0];
    for (int r = 0; r < X; r++) begin
      i_adder_mode[r] <= rsa_pkg::adder_mode_t'(vec_mem[vec_ptr + 3 + r][1:0]);
      i_m_data[r]     <= vec_mem[vec_ptr + 3 + X + r];
    end
    @(posedge clk);
    i_start <= 1'b0;
    for (int b = 0; b < k; b++) begin
      i_in_valid <= 1'b1;
      for (int r = 0; r < X; r++) begin
        i_a_data[r] <= vec_mem[beat + b * (X + Y) + r];
      end
      for (int c = 0; c < Y; c++) begin
        i_b_data[c] <= vec_mem[beat + b * (X + Y) + X + c];
      end
      @(posedge clk);
    end
    i_in_valid <= 1'b0;
    i_a_data   <= '0;
    i_b_data   <= '0;
    // stray start while the wavefront is still moving
    if (probe != 0) begin
      @(posedge clk);
      i_start <= 1'b1;
      i_mode  <= ~job_mode;
      i_k_len <= 1;
      @(posedge clk);
      i_start <= 1'b0;
    end
    while (o_done !== 1'b1) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
    for (int r = 0; r < X; r++) begin
      check_word(rx_cnt[r], Y, "valid count", r, 0);
      check_word(last_cyc[r] - first_cyc[r], Y - 1, "valid run length", r, 0);
      check_word(done_cyc - last_cyc[r], 1, "done after last valid", r, Y - 1);
    end
    check_word(done_cnt, 1, "done pulse count", 0, 0);
    check_word(o_busy, 1'b0, "busy after done", 0, 0);
    vec_ptr = beat + (X + Y) * k + X * Y;
  endtask

  // result monitor, column order follows the row direction
  always @(posedge clk) begin : monitor
    int col;
    if (i_in_valid) begin
      last_in_cyc = cyc;
    end
    if (o_done) begin
      done_cnt = done_cnt + 1;
      done_cyc = cyc;
    end
    for (int r = 0; r < X; r++) begin
      if (o_c_valid[r]) begin
        if (rx_cnt[r] == 0) begin
          first_cyc[r] = cyc;
          check_word(cyc - last_in_cyc, rsa_pkg::WAVE_LAT + 3, "first valid latency", r, 0);
        end
        if (rx_cnt[r] < Y) begin
          col = (job_mode[0] == rsa_pkg::DIR_W2E) ? rx_cnt[r] : Y - 1 - rx_cnt[r];
          check_word(o_c_data[r], exp_c[r][col], "result", r, col);
        end else begin
          errors++;
          $display("Row %0d gave more than %0d results at time %0t", r, Y, $time);
        end
        last_cyc[r] = cyc;
        rx_cnt[r]   = rx_cnt[r] + 1;
      end
    end
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= cycle_limit) begin
      errors++;
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Checked %0d values, %0d errors", checks,
               errors + u_dut.u_assertions.fail_cnt);
      $display("Errors found");
      $finish;
    end
  end

  initial begin
    int n_jobs;
    int p;
    clk         = 1'b0;
    i_rst_n     = 1'b0;
    i_start     = 1'b0;
    i_mode      = '0;
    i_k_len     = '0;
    i_in_valid  = 1'b0;
    i_a_data    = '0;
    i_b_data    = '0;
    i_m_data    = '0;
    for (int r = 0; r < X; r++) begin
      i_adder_mode[r] = rsa_pkg::ADD_PASS;
      rx_cnt[r]       = 0;
      first_cyc[r]    = 0;
      last_cyc[r]     = 0;
    end
    job_mode    = '0;
    checks      = 0;
    errors      = 0;
    cyc         = 0;
    done_cnt    = 0;
    done_cyc    = 0;
    last_in_cyc = 0;
    vec_ptr     = 1;
    cycle_limit = 1000;
    $readmemh("tb/rsa_vectors.txt", vec_mem);
    if ($isunknown(vec_mem[0])) begin
      errors++;
      $display("The vector file tb/rsa_vectors.txt could not be read");
    end else begin
      n_jobs = vec_mem[0];
      // length plus wave, drain and flush per job
      p           = 1;
      cycle_limit = 50;
      for (int j = 0; j < n_jobs; j++) begin
        cycle_limit = cycle_limit + vec_mem[p + 1] + X + Y + Y + 10;
        p           = p + HDR_WORDS + (X + Y) * vec_mem[p + 1] + X * Y;
      end
      repeat (8) @(posedge clk);
      i_rst_n <= 1'b1;
      for (int j = 0; j < n_jobs; j++) begin
        run_job();
      end
    end
    errors = errors + u_dut.u_assertions.fail_cnt;
    $display("Checked %0d values, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb/rsa_vectors.txt */
// job count, then per job: mode k probe, adder modes 0-3, M 0-3, then k beats of a0-a3 b0-b3
// then 16 expected C words row by row, column 0 first; all values hex
5
// W2E and N2S, pass on every row
0 3 0  0 0 0 0  0000 0000 0000 0000
0001 0004 0007 8000  0001 0002 0003 0004
0002 0005 0008 0100  0005 0006 0007 0008
0003 0006 0009 FFFF  0009 000A 000B 000C
0026 002C 0032 0038 0053 0062 0071 0080 0080 0098 00B0 00C8 84F7 05F6 86F5 07F4
// E2W and S2N, same operands
3 3 0  0 0 0 0  0000 0000 0000 0000
0001 0004 0007 8000  0001 0002 0003 0004
0002 0005 0008 0100  0005 0006 0007 0008
0003 0006 0009 FFFF  0009 000A 000B 000C
0026 002C 0032 0038 0053 0062 0071 0080 0080 0098 00B0 00C8 84F7 05F6 86F5 07F4
// E2W and N2S, mixed adder modes
1 2 0  1 2 3 0  FFF0 0100 0050 1234
0003 0002 0001 0400  0001 0002 0004 0008
0001 0002 0004 0010  0010 0020 0040 0080
0003 0016 003C 0088 FF22 FF44 FF88 0010 000F FFCE FF4C FE48 0500 0A00 1400 2800
// W2E and S2N, length 1
2 1 0  0 0 0 0  0000 0000 0000 0000
0002 0003 0004 0005  0010 0020 0030 0040
0020 0040 0060 0080 0030 0060 0090 00C0 0040 0080 00C0 0100 0050 00A0 00F0 0140
// W2E and N2S, length 16 with a stray start
0 10 1  0 0 0 0  0000 0000 0000 0000
0101 0202 0303 0404  0001 0002 0003 0004
0101 0202 0303 0404  0002 0004 0006 0008
0101 0202 0303 0404  0003 0006 0009 000C
0101 0202 0303 0404  0004 0008 000C 0010
0101 0202 0303 0404  0005 000A 000F 0014
0101 0202 0303 0404  0006 000C 0012 0018
0101 0202 0303 0404  0007 000E 0015 001C
0101 0202 0303 0404  0008 0010 0018 0020
0101 0202 0303 0404  0009 0012 001B 0024
0101 0202 0303 0404  000A 0014 001E 0028
0101 0202 0303 0404  000B 0016 0021 002C
0101 0202 0303 0404  000C 0018 0024 0030
0101 0202 0303 0404  000D 001A 0027 0034
0101 0202 0303 0404  000E 001C 002A 0038
0101 0202 0303 0404  000F 001E 002D 003C
0101 0202 0303 0404  0010 0020 0030 0040
8888 1110 9998 2220 1110 2220 3330 4440 9998 3330 CCC8 6660 2220 4440 6660 8880
